// ==== bipPkg.sv ====
package bipPkg;

	////////////////////
	// Widths

	localparam int AddrWidth = 11;	// Instruction and data address
	localparam int DataWidth = 16;	// Word and accumulator
	localparam int OpWidth = 5;	// Opcode field, top of the word
	localparam int MemDepth = 2048;	// Words per memory, full address range

	////////////////////
	// Instruction set

	// Word layout is opcode then operand, operand fills the low bits
	typedef enum logic [OpWidth-1:0]
	{
		HLT = 5'd0,	// Stop, PC holds
		STO = 5'd1,	// mem[op] = acc
		LD = 5'd2,	// acc = mem[op]
		LDI = 5'd3,	// acc = zext(op)
		ADD = 5'd4,	// acc = acc + mem[op]
		ADDI = 5'd5,	// acc = acc + zext(op)
		SUB = 5'd6,	// acc = acc - mem[op]
		SUBI = 5'd7	// acc = acc - zext(op)
	} opcodeT;	// Codes 8..31 decode as HLT

	////////////////////
	// Decoded control

	typedef struct packed
	{
		logic wrAcc;	// Accumulator loads this cycle
		logic selImm;	// Operand is the immediate, not the memory word
		logic selAlu;	// Accumulator takes the adder result
		logic subtract;	// Adder does acc - operand
		logic rd;	// Data memory read strobe
		logic wr;	// Data memory write strobe
		logic halt;	// Current instruction is HLT
	} ctrlT;

	// No-op control word
	// Used while idle (reset or halted)
	localparam ctrlT CtrlIdle = '0;

	////////////////////
	// Memory port

	typedef struct packed
	{
		logic en;	// Write strobe
		logic [AddrWidth-1:0] addr;	// Word address
		logic [DataWidth-1:0] data;	// Word to store
	} memWriteT;

endpackage

// ==== bipControl.sv ====
`timescale 1ns/1ps

module bipControl
(
	input logic Clock,
	input logic rst,
	input logic [bipPkg::DataWidth-1:0] instruction,	// From program memory
	output logic [bipPkg::AddrWidth-1:0] insAddr,	// To program memory
	output bipPkg::ctrlT ctrl,	// To datapath and strobes
	output logic [bipPkg::AddrWidth-1:0] operand,	// Low field of the instruction
	output logic halted
);

	logic [bipPkg::AddrWidth-1:0] pc;
	bipPkg::opcodeT opcode;
	bipPkg::ctrlT decoded;

	// Field split, opcode on top
	assign opcode = bipPkg::opcodeT'(instruction[bipPkg::DataWidth-1 -: bipPkg::OpWidth]);
	assign operand = instruction[bipPkg::AddrWidth-1:0];

	////////////////////
	// Decoder

	always_comb
	begin
		decoded = bipPkg::CtrlIdle;
		case (opcode)
			bipPkg::STO: decoded.wr = 1'b1;	// Store acc
			bipPkg::LD:
			begin
				decoded.rd = 1'b1;
				decoded.wrAcc = 1'b1;	// Memory word straight in
			end
			bipPkg::LDI:
			begin
				decoded.selImm = 1'b1;
				decoded.wrAcc = 1'b1;
			end
			bipPkg::ADD, bipPkg::SUB:
			begin
				decoded.rd = 1'b1;	// Operand from memory
				decoded.selAlu = 1'b1;
				decoded.wrAcc = 1'b1;
				decoded.subtract = (opcode == bipPkg::SUB);
			end
			bipPkg::ADDI, bipPkg::SUBI:
			begin
				decoded.selImm = 1'b1;	// Operand from the word itself
				decoded.selAlu = 1'b1;
				decoded.wrAcc = 1'b1;
				decoded.subtract = (opcode == bipPkg::SUBI);
			end
			default: decoded.halt = 1'b1;	// HLT and every unused code
		endcase
	end

	// Core does nothing in reset or after HLT, so strobes stay low
	assign ctrl = (rst || halted) ? bipPkg::CtrlIdle : decoded;

	////////////////////
	// PC and halt state

	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			pc <= '0;
			halted <= 1'b0;
		end
		else
		begin
			if (!halted && !decoded.halt)
				pc <= pc + 1'b1;	// One instruction per cycle
			if (decoded.halt)
				halted <= 1'b1;	// Sticky until next reset
		end
	end

	assign insAddr = pc;

endmodule

// ==== bipDatapath.sv ====
`timescale 1ns/1ps

module bipDatapath
(
	input logic Clock,
	input logic rst,
	input bipPkg::ctrlT ctrl,	// From decoder
	input logic [bipPkg::AddrWidth-1:0] operand,	// Immediate or address
	input logic [bipPkg::DataWidth-1:0] outData,	// Data memory word
	output logic [bipPkg::DataWidth-1:0] inData	// Accumulator to data memory
);

	logic [bipPkg::DataWidth-1:0] acc;
	logic [bipPkg::DataWidth-1:0] immExt;	// Zero-extended operand
	logic [bipPkg::DataWidth-1:0] aluB;
	logic [bipPkg::DataWidth-1:0] aluOut;
	logic [bipPkg::DataWidth-1:0] accNext;

	////////////////////
	// Operand selection

	// Upper 5 bits always zero, LDI 7FF gives 07FF
	assign immExt = {{(bipPkg::DataWidth - bipPkg::AddrWidth){1'b0}}, operand};

	// Second adder input
	assign aluB = ctrl.selImm ? immExt : outData;

	////////////////////
	// Add / subtract

	// Plain 16-bit result, carry and borrow dropped
	assign aluOut = ctrl.subtract ? (acc - aluB) : (acc + aluB);

	// Accumulator source
	always_comb
	begin
		if (ctrl.selAlu)
			accNext = aluOut;	// ADD, ADDI, SUB, SUBI
		else if (ctrl.selImm)
			accNext = immExt;	// LDI
		else
			accNext = outData;	// LD
	end

	////////////////////
	// Accumulator

	always_ff @(posedge Clock)
	begin
		if (rst)
			acc <= '0;
		else if (ctrl.wrAcc)
			acc <= accNext;	// Holds on STO and HLT
	end

	// STO writes whatever is in acc
	assign inData = acc;

endmodule

// ==== bipCpu.sv ====
`timescale 1ns/1ps

module bipCpu
(
	output logic [bipPkg::AddrWidth-1:0] insAddr,	// Program memory address
	input logic [bipPkg::DataWidth-1:0] instruction,	// Program memory word
	output logic rd,	// Data memory read
	output logic wr,	// Data memory write
	output logic [bipPkg::AddrWidth-1:0] dataAddr,	// Data memory address
	output logic [bipPkg::DataWidth-1:0] inData,	// Word to data memory
	input logic [bipPkg::DataWidth-1:0] outData,	// Word from data memory
	input logic Clock,
	input logic rst,
	output logic halted	// HLT reached
);

	bipPkg::ctrlT ctrl;
	logic [bipPkg::AddrWidth-1:0] operand;

	// Fetch, decode, PC
	bipControl control_i
	(
		.Clock(Clock),
		.rst(rst),
		.instruction(instruction),
		.insAddr(insAddr),
		.ctrl(ctrl),
		.operand(operand),
		.halted(halted)
	);

	// Accumulator and adder
	bipDatapath datapath_i
	(
		.Clock(Clock),
		.rst(rst),
		.ctrl(ctrl),
		.operand(operand),
		.outData(outData),
		.inData(inData)
	);

	// Memory side of the core
	assign rd = ctrl.rd;
	assign wr = ctrl.wr;
	assign dataAddr = operand;	// Direct addressing only

endmodule

// ==== bipMemory.sv ====
`timescale 1ns/1ps

module bipMemory
(
	input logic Clock,
	input bipPkg::memWriteT write,	// Synchronous write port
	input logic [bipPkg::AddrWidth-1:0] addrA,
	output logic [bipPkg::DataWidth-1:0] dataA,	// Async read A
	input logic [bipPkg::AddrWidth-1:0] addrB,
	output logic [bipPkg::DataWidth-1:0] dataB	// Async read B
);

	////////////////////
	// Storage

	// One word per address, MemDepth covers all of AddrWidth
	logic [bipPkg::DataWidth-1:0] mem [bipPkg::MemDepth];

	// Write lands at the clock edge
	always_ff @(posedge Clock)
	begin
		if (write.en)
			mem[write.addr] <= write.data;
	end

	////////////////////
	// Read ports

	// Same-cycle answer, no wait states
	// A read of the address being written returns the old word
	assign dataA = mem[addrA];
	assign dataB = mem[addrB];	// Second port for debug or spare

endmodule

// ==== bipSystem.sv ====
`timescale 1ns/1ps

module bipSystem
(
	input logic Clock,
	input logic rst,
	input bipPkg::memWriteT progWrite,	// Program load, used during reset
	input logic [bipPkg::AddrWidth-1:0] dbgAddr,	// Data memory peek address
	output logic [bipPkg::DataWidth-1:0] dbgData,	// Data memory peek word
	output logic halted	// Program finished
);

	logic [bipPkg::AddrWidth-1:0] insAddr;
	logic [bipPkg::DataWidth-1:0] instruction;
	logic wr;
	logic [bipPkg::AddrWidth-1:0] dataAddr;
	logic [bipPkg::DataWidth-1:0] inData;
	logic [bipPkg::DataWidth-1:0] outData;
	bipPkg::memWriteT dataWrite;

	// Core write strobe as a memory port
	assign dataWrite = '{en: wr, addr: dataAddr, data: inData};

	////////////////////
	// Core

	bipCpu cpu_i
	(
		.insAddr(insAddr),
		.instruction(instruction),
		.rd(),	// Reads are asynchronous, strobe not needed here
		.wr(wr),
		.dataAddr(dataAddr),
		.inData(inData),
		.outData(outData),
		.Clock(Clock),
		.rst(rst),
		.halted(halted)
	);

	////////////////////
	// Memories

	bipMemory progMem_i
	(
		.Clock(Clock),
		.write(progWrite),	// Loaded by the testbench
		.addrA(insAddr),
		.dataA(instruction),
		.addrB('0),	// Spare port
		.dataB()
	);

	bipMemory dataMem_i
	(
		.Clock(Clock),
		.write(dataWrite),	// STO path
		.addrA(dataAddr),
		.dataA(outData),	// LD, ADD, SUB path
		.addrB(dbgAddr),
		.dataB(dbgData)	// Testbench readback
	);

endmodule

// ==== bipSystem_chk.sv ====
`timescale 1ns/1ps

module bipSystem_chk
(
	input logic Clock,
	input logic rst,
	input logic rd,
	input logic wr,
	input logic halted,
	input logic [bipPkg::AddrWidth-1:0] insAddr,
	input logic [bipPkg::DataWidth-1:0] instruction
);

	logic [bipPkg::OpWidth-1:0] opField;
	logic haltNow;	// HLT or an unused code

	assign opField = instruction[bipPkg::DataWidth-1 -: bipPkg::OpWidth];
	assign haltNow = (opField == 5'd0) || (opField > 5'd7);

	////////////////////
	// Strobes

	assert property (@(posedge Clock) !(rd && wr))
		else $error("rd and wr high in the same cycle");
	assert property (@(posedge Clock) (rst || halted) |-> !(rd || wr))
		else $error("data strobe high in reset or after halt");

	////////////////////
	// Program counter

	assert property (@(posedge Clock) disable iff (rst)
		(!halted && !haltNow) |=> (insAddr == $past(insAddr) + 11'd1))
		else $error("insAddr did not step by one");
	assert property (@(posedge Clock) disable iff (rst) halted |=> $stable(insAddr))
		else $error("insAddr moved after halt");

endmodule

bind bipCpu bipSystem_chk chk_i
(
	.Clock(Clock),
	.rst(rst),
	.rd(rd),
	.wr(wr),
	.halted(halted),
	.insAddr(insAddr),
	.instruction(instruction)
);

// ==== tb_bipSystem.sv ====
`timescale 1ns/1ps

module tb_bipSystem;

	localparam int MaxCycles = bipPkg::MemDepth + 64;	// Watchdog budget per test

	logic Clock;
	logic rst;
	bipPkg::memWriteT progWrite;
	logic [bipPkg::AddrWidth-1:0] dbgAddr;
	logic [bipPkg::DataWidth-1:0] dbgData;
	logic halted;

	// Vector file contents tagged with their test index
	int tId[$], tCount[$];
	int pTest[$], pAddr[$], pWord[$];
	int eTest[$], eAddr[$], eVal[$];
	int numTests;
	int errors;	// Mismatches in the running test
	int passCount;
	int failCount;
	bit loaded;

	bipSystem bipSystem_i
	(
		.Clock(Clock),
		.rst(rst),
		.progWrite(progWrite),
		.dbgAddr(dbgAddr),
		.dbgData(dbgData),
		.halted(halted)
	);

	always #10 Clock = ~Clock;	// 20 ns period

	////////////////////
	// Compare

	task automatic checkEqual(input string name, input logic [bipPkg::DataWidth-1:0] expected,
		input logic [bipPkg::DataWidth-1:0] actual);
		if (actual !== expected)
		begin
			$display("Error: %s expected %h got %h", name, expected, actual);
			errors++;
		end
	endtask

	////////////////////
	// One test

	task automatic runTest(input int t);
		int haltAt;	// Edges from reset release to halted
		int edges;
		int seen;
		int i;
		haltAt = 0;
		edges = 0;
		seen = 0;
		errors = 0;
		@(negedge Clock);
		rst = 1'b1;
		for (i = 0; i < pTest.size(); i++)
		begin
			if (pTest[i] == t)
			begin
				progWrite = '{en: 1'b1, addr: pAddr[i][10:0], data: pWord[i][15:0]};
				if (pWord[i][15:11] == 5'd0 && haltAt == 0)
					haltAt = pAddr[i] + 1;	// N instructions then HLT gives N+1
				@(negedge Clock);	// Word lands on the rising edge between
			end
		end
		progWrite = '0;
		repeat (5) @(negedge Clock);	// Reset tail
		rst = 1'b0;
		while (!halted)
		begin
			@(negedge Clock);
			edges++;
		end
		checkEqual("halt edges", 16'(haltAt), 16'(edges));
		for (i = 0; i < eTest.size(); i++)
		begin
			if (eTest[i] == t)
			begin
				dbgAddr = eAddr[i][10:0];
				@(posedge Clock);	// Async read settled long before
				checkEqual($sformatf("dbgData[%h]", eAddr[i][10:0]), eVal[i][15:0], dbgData);
				@(negedge Clock);
				seen++;
			end
		end
		checkEqual("halted", 16'(1), 16'(halted));	// Still set after readback
		if (seen != tCount[t])
		begin
			$display("Test %0d lists %0d expected words but its header says %0d",
				tId[t], seen, tCount[t]);
			errors++;
		end
		if (errors == 0)
		begin
			passCount++;
			$display("Test %0d: pass", tId[t]);
		end
		else
		begin
			failCount++;
			$display("Test %0d: %0d mismatches", tId[t], errors);
		end
	endtask

	////////////////////
	// Main sequence

	initial
	begin
		int fd;
		int code;
		int a;
		int b;
		int t;
		bit badLine;	// Some T, P or E line lacked its two fields
		logic [7:0] tok;
		logic [8*128-1:0] rest;
		Clock = 1'b0;
		rst = 1'b1;
		progWrite = '0;
		dbgAddr = '0;
		numTests = 0;
		passCount = 0;
		failCount = 0;
		loaded = 1'b0;
		badLine = 1'b0;
		fd = $fopen("bip_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open bip_vectors.txt");
			failCount++;
		end
		else
		begin
			while ($fscanf(fd, "%s", tok) == 1)
			begin
				if (tok == "T")
				begin
					code = $fscanf(fd, "%d %d", a, b);
					badLine |= (code != 2);
					tId.push_back(a);
					tCount.push_back(b);
					numTests++;
				end
				else if (tok == "P")
				begin
					code = $fscanf(fd, "%h %h", a, b);
					badLine |= (code != 2);
					pTest.push_back(numTests - 1);
					pAddr.push_back(a);
					pWord.push_back(b);
				end
				else if (tok == "E")
				begin
					code = $fscanf(fd, "%h %h", a, b);
					badLine |= (code != 2);
					eTest.push_back(numTests - 1);
					eAddr.push_back(a);
					eVal.push_back(b);
				end
				else
					code = $fgets(rest, fd);	// Comment line
			end
			$fclose(fd);
			if (badLine)
			begin
				$display("A line in bip_vectors.txt is missing its two fields");
				failCount++;
			end
		end
		loaded = 1'b1;
		for (t = 0; t < numTests; t++)
			runTest(t);
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0 && numTests > 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Stuck program guard
	initial
	begin
		wait (loaded && numTests > 0);
		repeat (numTests * MaxCycles) @(posedge Clock);
		$display("Watchdog expired because the program did not halt");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== bip_vectors.txt ====
# T test-id expected-count (decimal) | P addr word (hex) | E addr value (hex)
# Word is opcode in bits 15..11 and operand in bits 10..0
T 1 1
P 000 1801
P 001 0800
P 002 1000
P 003 2801
P 004 0800
P 005 0000
E 000 0002
T 2 3
P 000 1923
P 001 0FFF
P 002 1C56
P 003 0800
P 004 17FF
P 005 0803
P 006 0000
E 7FF 0123
E 000 0456
E 003 0123
T 3 4
P 000 1800
P 001 3801
P 002 0820
P 003 2802
P 004 0821
P 005 3020
P 006 0822
P 007 2020
P 008 0823
P 009 0000
E 020 FFFF
E 021 0001
E 022 0002
E 023 0001
T 4 1
P 000 1800
P 001 3801
P 002 1FFF
P 003 0830
P 004 0000
E 030 07FF
T 5 3
P 000 1855
P 001 0840
P 002 0000
P 003 0800
E 040 0055
E 000 0456
E 023 0001

// ==== tb.f ====
bipPkg.sv
bipControl.sv
bipDatapath.sv
bipCpu.sv
bipMemory.sv
bipSystem.sv
bipSystem_chk.sv
tb_bipSystem.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of tb_bipSystem, verdict taken from sim.log
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_bipSystem -f tb.f > build.log 2>&1 \
	&& ./obj_dir/Vtb_bipSystem > sim.log 2>&1 \
	|| echo "CHECKS FAILED (build or simulator error)" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
